//--- Makefile
# Verilator flow for the spike filter array

VERILATOR  ?= verilator
TOP        := spikeFilterArrayTb
DUT_TOP    := spikeFilterArray
FILELIST   := spikeFilter.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/fixedPointPkg.sv
`default_nettype none

package fixedPointPkg;

  import spikeFilterPkg::*;

  // decay constant is an unsigned fraction with this many fraction bits.
  // 1.0 would be 2**fracWidth, which the port cannot carry
  localparam int fracWidth = 27;

  // state saturates here instead of wrapping
  localparam logic [stateWidth-1:0] stateMax = '1;

  // output FIFO entries
  localparam int fifoDepth = 4;

endpackage

`default_nettype wire

//--- common/spikeFilterPkg.sv
`default_nettype none

package spikeFilterPkg;

  // filter array geometry

  // number of filters in the array
  localparam int nFilts = 10;

  // filter index carried on the input tag and output word
  localparam int tagWidth = 4;

  // spike count per event
  localparam int ctWidth = 10;

  // accumulated filter state
  localparam int stateWidth = 27;

  // filters-used setting, holds 0 to nFilts
  localparam int usedWidth = 4;

endpackage

`default_nettype wire

//--- dv/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
  output logic clk
);

  // 20 ns period
  localparam int halfPeriod = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- dv/spikeFilterArrayTb.sv
`timescale 1ns/100ps
`default_nettype none

module spikeFilterArrayTb
  import spikeFilterPkg::*;
  import fixedPointPkg::*;
();

  typedef enum {opEvent, opUpdate, opConfig} opKind;

  // event uses a as tag and b as count
  // config uses a, b, c as increment, decay, filters used
  typedef struct {
    int          testNum;
    opKind       op;
    int unsigned a;
    int unsigned b;
    int unsigned c;
    bit          randReady;
  } stepRow;

  localparam int drainLimit = 100;

  logic                  clk;
  logic                  reset;
  logic                  inValid;
  logic [tagWidth-1:0]   inTag;
  logic [ctWidth-1:0]    inCt;
  logic                  inReady;
  logic                  outValid;
  logic [tagWidth-1:0]   outFiltIdx;
  logic [stateWidth-1:0] outFiltState;
  logic                  outReady;
  logic [stateWidth-1:0] incrementConstant;
  logic [fracWidth-1:0]  decayConstant;
  logic [usedWidth-1:0]  filtsUsed;
  logic                  updatePulse;

  stepRow steps[$];
  string  testNames [5] = '{"unused filters", "count mode", "decay mode",
                            "saturation", "back-pressure"};

  // reference model
  longint unsigned modelState [nFilts];
  longint unsigned modelInc = 0;
  longint unsigned modelDecay = 0;
  longint unsigned modelUsed = 0;
  int unsigned     expIdx[$];
  longint unsigned expState[$];

  int          errors = 0;
  int          checks = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          testErrStart = 0;
  int          cycleCount = 0;
  int          cycleLimit = 0;
  bit          randMode = 1'b0;
  logic [31:0] lcgState = 32'hd89a;

  clockGen i_clockGen (
    .clk (clk)
  );

  spikeFilterArray i_spikeFilterArray (
    .clk               (clk),
    .reset             (reset),
    .inValid           (inValid),
    .inTag             (inTag),
    .inCt              (inCt),
    .inReady           (inReady),
    .outValid          (outValid),
    .outFiltIdx        (outFiltIdx),
    .outFiltState      (outFiltState),
    .outReady          (outReady),
    .incrementConstant (incrementConstant),
    .decayConstant     (decayConstant),
    .filtsUsed         (filtsUsed),
    .updatePulse       (updatePulse)
  );

  function automatic logic nextRandomBit();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[16];
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] expected);
    checks++;
    if (got !== expected) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
      errors++;
    end
  endtask

  task automatic addStep(input int testNum, input opKind op, input int unsigned a,
                         input int unsigned b, input int unsigned c, input bit randReady);
    stepRow row;
    row = '{testNum, op, a, b, c, randReady};
    steps.push_back(row);
  endtask

  task automatic buildTable();
    addStep(0, opConfig, 1, 0, 0, 1'b0);
    addStep(0, opEvent, 0, 3, 0, 1'b0);
    addStep(0, opEvent, 1, 4, 0, 1'b0);
    addStep(0, opUpdate, 0, 0, 0, 1'b0);
    addStep(0, opConfig, 1, 0, 2, 1'b0);
    addStep(0, opUpdate, 0, 0, 0, 1'b0);
    addStep(1, opEvent, 0, 1, 0, 1'b0);
    addStep(1, opEvent, 1, 2, 0, 1'b0);
    addStep(1, opEvent, 0, 1, 0, 1'b0);
    addStep(1, opEvent, 1, 2, 0, 1'b0);
    addStep(1, opUpdate, 0, 0, 0, 1'b0);
    addStep(1, opUpdate, 0, 0, 0, 1'b0);
    addStep(2, opConfig, 5120, 134083577, 10, 1'b0);
    addStep(2, opEvent, 0, 100, 0, 1'b0);
    addStep(2, opEvent, 3, 1023, 0, 1'b0);
    addStep(2, opEvent, 9, 500, 0, 1'b0);
    addStep(2, opUpdate, 0, 0, 0, 1'b0);
    addStep(2, opEvent, 0, 50, 0, 1'b0);
    addStep(2, opUpdate, 0, 0, 0, 1'b0);
    addStep(2, opUpdate, 0, 0, 0, 1'b0);
    addStep(3, opConfig, 32'h100_0000, 134083577, 4, 1'b0);
    addStep(3, opEvent, 2, 1023, 0, 1'b0);
    addStep(3, opEvent, 3, 4, 0, 1'b0);
    addStep(3, opEvent, 3, 4, 0, 1'b0);
    addStep(3, opUpdate, 0, 0, 0, 1'b0);
    addStep(4, opConfig, 7, 32'h400_0000, 10, 1'b1);
    addStep(4, opEvent, 1, 10, 0, 1'b1);
    addStep(4, opEvent, 8, 30, 0, 1'b1);
    addStep(4, opUpdate, 0, 0, 0, 1'b1);
    addStep(4, opEvent, 1, 5, 0, 1'b1);
    addStep(4, opEvent, 6, 9, 0, 1'b1);
    addStep(4, opEvent, 12, 3, 0, 1'b1);
    addStep(4, opUpdate, 0, 0, 0, 1'b1);
    addStep(4, opUpdate, 0, 0, 0, 1'b1);
  endtask

  // tags at or above filters used are dropped
  function automatic void modelEvent(input int unsigned tag, input int unsigned ct);
    longint unsigned amount;
    if (tag < modelUsed) begin
      amount = longint'(ct) * modelInc;
      if (amount > stateMax) begin
        amount = stateMax;
      end
      modelState[tag] = modelState[tag] + amount;
      if (modelState[tag] > stateMax) begin
        modelState[tag] = stateMax;
      end
    end
  endfunction

  // words carry the state before decay
  function automatic void modelUpdate();
    for (int i = 0; i < modelUsed; i++) begin
      expIdx.push_back(i);
      expState.push_back(modelState[i]);
      modelState[i] = (modelState[i] * modelDecay) >> fracWidth;
    end
  endfunction

  task automatic takeWord();
    if (expIdx.size() == 0) begin
      $display("extra output word after the sweep, index %0d state 0x%0h",
               outFiltIdx, outFiltState);
      errors++;
    end else begin
      checkValue("outFiltIdx", outFiltIdx, expIdx.pop_front());
      checkValue("outFiltState", outFiltState, expState.pop_front());
    end
  endtask

  // wait for every expected word, then let the intake settle
  task automatic drainOutputs();
    int waited;
    waited = 0;
    while (expIdx.size() != 0 && waited < drainLimit) begin
      @(posedge clk);
      waited++;
    end
    if (expIdx.size() != 0) begin
      $display("missing %0d output words, the DUT stopped sending", expIdx.size());
      errors++;
      expIdx.delete();
      expState.delete();
    end
    repeat (4) @(posedge clk);
    #2;
  endtask

  task automatic sendEvent(input int unsigned tag, input int unsigned ct);
    inTag   = tag;
    inCt    = ct;
    inValid = 1'b1;
    do begin
      @(negedge clk);
    end while (!inReady);
    @(posedge clk);
    #2;
    inValid = 1'b0;
  endtask

  task automatic pulseUpdate();
    updatePulse = 1'b1;
    @(posedge clk);
    #2;
    updatePulse = 1'b0;
  endtask

  task automatic applyConfig(input int unsigned inc, input int unsigned decay,
                             input int unsigned used);
    incrementConstant = inc;
    decayConstant     = decay;
    filtsUsed         = used;
    modelInc          = inc;
    modelDecay        = decay;
    modelUsed         = used;
  endtask

  task automatic finishTest(input int testNum);
    drainOutputs();
    testsRun++;
    if (errors != testErrStart) begin
      testsFailed++;
    end
    $display("test %0d %s: %s, %0d errors", testNum, testNames[testNum],
             (errors == testErrStart) ? "pass" : "fail", errors - testErrStart);
  endtask

  // sink drives outReady a little after each rising edge
  initial begin
    bit useRand;
    outReady = 1'b0;
    forever begin
      @(posedge clk);
      useRand = randMode;
      #2;
      outReady = useRand ? nextRandomBit() : 1'b1;
    end
  end

  // a word moves on the next edge when both are high at the falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (!reset && outValid && outReady) begin
        takeWord();
      end
    end
  end

  initial begin
    wait (cycleLimit != 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: no result after %0d cycles", cycleLimit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    stepRow row;
    int     curTest;
    reset             = 1'b1;
    inValid           = 1'b0;
    inTag             = '0;
    inCt              = '0;
    updatePulse       = 1'b0;
    incrementConstant = '0;
    decayConstant     = '0;
    filtsUsed         = '0;
    foreach (modelState[i]) begin
      modelState[i] = 0;
    end
    buildTable();
    cycleLimit = steps.size() * 40 + 200;
    repeat (16) @(posedge clk);
    #2;
    reset   = 1'b0;
    curTest = -1;
    foreach (steps[i]) begin
      row = steps[i];
      if (row.testNum != curTest) begin
        if (curTest >= 0) begin
          finishTest(curTest);
        end
        curTest      = row.testNum;
        testErrStart = errors;
      end
      randMode = row.randReady;
      case (row.op)
        opEvent: begin
          modelEvent(row.a, row.b);
          sendEvent(row.a, row.b);
        end
        opUpdate: begin
          drainOutputs();
          modelUpdate();
          pulseUpdate();
        end
        default: begin
          drainOutputs();
          applyConfig(row.a, row.b, row.c);
        end
      endcase
    end
    finishTest(curTest);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/filterOutFifo.sv
`timescale 1ns/100ps
`default_nettype none

module filterOutFifo
  import spikeFilterPkg::*;
  import fixedPointPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,

  // write side from the state bank
  input  logic                  pushValid,
  input  logic [tagWidth-1:0]   pushIdx,
  input  logic [stateWidth-1:0] pushState,
  output logic                  pushReady,

  // read side, head word shown without a request
  output logic                  outValid,
  output logic [tagWidth-1:0]   outFiltIdx,
  output logic [stateWidth-1:0] outFiltState,
  input  logic                  outReady
);

  logic [tagWidth+stateWidth-1:0]   mem [fifoDepth];
  logic [$clog2(fifoDepth)-1:0]     wrPtr;
  logic [$clog2(fifoDepth)-1:0]     rdPtr;
  logic [$clog2(fifoDepth+1)-1:0]   count;
  logic                             pushXfer;
  logic                             popXfer;

  assign pushReady = count != fifoDepth;
  assign outValid  = count != '0;
  assign pushXfer  = pushValid && pushReady;
  assign popXfer   = outValid && outReady;

  assign {outFiltIdx, outFiltState} = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (pushXfer) begin
      mem[wrPtr] <= {pushIdx, pushState};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (pushXfer) begin
        wrPtr <= (wrPtr == fifoDepth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (popXfer) begin
        rdPtr <= (rdPtr == fifoDepth - 1) ? '0 : rdPtr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({pushXfer, popXfer})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  countInRange: assert property (@(posedge clk) disable iff (reset)
    count <= fifoDepth);

endmodule

`default_nettype wire

//--- hdl/spikeFilterArray.sv
`timescale 1ns/100ps
`default_nettype none

module spikeFilterArray
  import spikeFilterPkg::*;
  import fixedPointPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,

  // spike event input
  input  logic                  inValid,
  input  logic [tagWidth-1:0]   inTag,
  input  logic [ctWidth-1:0]    inCt,
  output logic                  inReady,

  // filter output words
  output logic                  outValid,
  output logic [tagWidth-1:0]   outFiltIdx,
  output logic [stateWidth-1:0] outFiltState,
  input  logic                  outReady,

  // static configuration
  input  logic [stateWidth-1:0] incrementConstant,
  input  logic [fracWidth-1:0]  decayConstant,
  input  logic [usedWidth-1:0]  filtsUsed,

  input  logic                  updatePulse
);

  // intake to bank
  logic                  incValid;
  logic [tagWidth-1:0]   incIdx;
  logic [stateWidth-1:0] incAmount;
  logic                  incReady;

  // bank to output FIFO
  logic                  pushValid;
  logic [tagWidth-1:0]   pushIdx;
  logic [stateWidth-1:0] pushState;
  logic                  pushReady;

  tagIntake i_tagIntake (
    .clk               (clk),
    .reset             (reset),
    .inValid           (inValid),
    .inTag             (inTag),
    .inCt              (inCt),
    .inReady           (inReady),
    .filtsUsed         (filtsUsed),
    .incrementConstant (incrementConstant),
    .incValid          (incValid),
    .incIdx            (incIdx),
    .incAmount         (incAmount),
    .incReady          (incReady)
  );

  filterStateBank i_filterStateBank (
    .clk           (clk),
    .reset         (reset),
    .incValid      (incValid),
    .incIdx        (incIdx),
    .incAmount     (incAmount),
    .incReady      (incReady),
    .updatePulse   (updatePulse),
    .filtsUsed     (filtsUsed),
    .decayConstant (decayConstant),
    .pushValid     (pushValid),
    .pushIdx       (pushIdx),
    .pushState     (pushState),
    .pushReady     (pushReady)
  );

  filterOutFifo i_filterOutFifo (
    .clk          (clk),
    .reset        (reset),
    .pushValid    (pushValid),
    .pushIdx      (pushIdx),
    .pushState    (pushState),
    .pushReady    (pushReady),
    .outValid     (outValid),
    .outFiltIdx   (outFiltIdx),
    .outFiltState (outFiltState),
    .outReady     (outReady)
  );

endmodule

`default_nettype wire

//--- spikeFilter.f
common/spikeFilterPkg.sv
common/fixedPointPkg.sv
spikeFilterBank/tagIntake.sv
spikeFilterBank/filterStateBank.sv
hdl/filterOutFifo.sv
hdl/spikeFilterArray.sv
dv/clockGen.sv
dv/spikeFilterArrayTb.sv

//--- spikeFilterBank/filterStateBank.sv
`timescale 1ns/100ps
`default_nettype none

module filterStateBank
  import spikeFilterPkg::*;
  import fixedPointPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,

  // increments from the intake
  input  logic                  incValid,
  input  logic [tagWidth-1:0]   incIdx,
  input  logic [stateWidth-1:0] incAmount,
  output logic                  incReady,

  // sweep control and configuration
  input  logic                  updatePulse,
  input  logic [usedWidth-1:0]  filtsUsed,
  input  logic [fracWidth-1:0]  decayConstant,

  // (index, state) words towards the output FIFO
  output logic                  pushValid,
  output logic [tagWidth-1:0]   pushIdx,
  output logic [stateWidth-1:0] pushState,
  input  logic                  pushReady
);

  logic [stateWidth-1:0]           state [nFilts];

  // sweep FSM is a busy flag plus the filter counter
  logic                            sweeping;
  logic [tagWidth-1:0]             sweepIdx;
  logic [tagWidth-1:0]             nextIdx;
  logic                            lastStep;

  logic                            incXfer;
  logic                            pushXfer;
  logic [stateWidth:0]             accSum;
  logic [stateWidth-1:0]           accState;
  logic [stateWidth+fracWidth-1:0] decayProduct;
  logic [stateWidth-1:0]           decayState;

  // increments stall while the sweep owns the state
  assign incReady = !sweeping;
  assign incXfer  = incValid && incReady;

  // accumulate with saturation on carry out
  assign accSum   = state[incIdx] + incAmount;
  assign accState = accSum[stateWidth] ? stateMax : accSum[stateWidth-1:0];

  // output word is the state before decay
  assign pushValid = sweeping;
  assign pushIdx   = sweepIdx;
  assign pushState = state[sweepIdx];
  assign pushXfer  = pushValid && pushReady;

  // integer part of state times fraction
  assign decayProduct = pushState * decayConstant;
  assign decayState   = decayProduct[fracWidth +: stateWidth];

  assign nextIdx  = sweepIdx + 1'b1;
  assign lastStep = nextIdx == filtsUsed;

  always_ff @(posedge clk) begin
    if (reset) begin
      sweeping <= 1'b0;
      sweepIdx <= '0;
    end else if (!sweeping) begin
      // nothing to sweep with no filters in use
      if (updatePulse) begin
        sweeping <= filtsUsed != '0;
        sweepIdx <= '0;
      end
    end else if (pushXfer) begin
      if (lastStep) begin
        sweeping <= 1'b0;
        sweepIdx <= '0;
      end else begin
        sweepIdx <= nextIdx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < nFilts; i++) begin
        state[i] <= '0;
      end
    end else if (incXfer) begin
      state[incIdx] <= accState;
    end else if (pushXfer) begin
      state[sweepIdx] <= decayState;
    end
  end

  // during a sweep only the swept filter may change, so no increment gets in
  for (genvar g = 0; g < nFilts; g++) begin : gSweepHold
    noIncDuringSweep: assert property (@(posedge clk) disable iff (reset)
      sweeping && (sweepIdx != g) |=> $stable(state[g]));
  end

  // sweep never walks past the filters in use
  pushIdxInRange: assert property (@(posedge clk) disable iff (reset)
    pushValid |-> pushIdx < filtsUsed);

endmodule

`default_nettype wire

//--- spikeFilterBank/tagIntake.sv
`timescale 1ns/100ps
`default_nettype none

module tagIntake
  import spikeFilterPkg::*;
  import fixedPointPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,

  // spike events from the source
  input  logic                  inValid,
  input  logic [tagWidth-1:0]   inTag,
  input  logic [ctWidth-1:0]    inCt,
  output logic                  inReady,

  // configuration
  input  logic [usedWidth-1:0]  filtsUsed,
  input  logic [stateWidth-1:0] incrementConstant,

  // increments towards the state bank
  output logic                  incValid,
  output logic [tagWidth-1:0]   incIdx,
  output logic [stateWidth-1:0] incAmount,
  input  logic                  incReady
);

  logic                          inXfer;
  logic                          incXfer;
  logic                          tagInRange;
  logic [ctWidth+stateWidth-1:0] rawProduct;
  logic [stateWidth-1:0]         satAmount;

  // one-entry output register
  logic                          regValid;
  logic [tagWidth-1:0]           regIdx;
  logic [stateWidth-1:0]         regAmount;

  assign incXfer = regValid && incReady;

  // free slot, or the held entry leaves this cycle
  assign inReady = !regValid || incReady;
  assign inXfer  = inValid && inReady;

  // tags at or above filtsUsed are consumed and dropped
  assign tagInRange = inTag < filtsUsed;

  // count times increment, clipped to the state range
  assign rawProduct = inCt * incrementConstant;
  assign satAmount  = (|rawProduct[ctWidth+stateWidth-1:stateWidth]) ?
                      stateMax : rawProduct[stateWidth-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      regValid <= 1'b0;
    end else if (inXfer) begin
      regValid <= tagInRange;
    end else if (incXfer) begin
      regValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (inXfer && tagInRange) begin
      regIdx    <= inTag;
      regAmount <= satAmount;
    end
  end

  assign incValid  = regValid;
  assign incIdx    = regIdx;
  assign incAmount = regAmount;

  // a stalled event must be held by the source until it is taken
  inputHeld: assert property (@(posedge clk) disable iff (reset)
    inValid && !inReady |=> inValid && $stable(inTag) && $stable(inCt));

endmodule

`default_nettype wire
